// ==== flag_rf.f ====
flag_rf_pkg.sv
flag_rf_bank.sv
flag_rf_tile.sv
flag_rf_array.sv
flag_rf_bypass.sv
flag_rf.sv
flag_rf_checker.sv
flag_rf_tb.sv

// ==== flag_rf.sv ====
// flags register file top; reads are valid the cycle after the strobe, no back-pressure
`timescale 1ns/1ps

module flag_rf (
  input  logic                                  clk,
  input  logic                                  rst,
  input  flag_rf_pkg::flag_rd_t                 rd,
  output flag_rf_pkg::flag_entry_t              rd_data,
  output logic [flag_rf_pkg::WR_PORTS:0]        rd_bypass,
  input  flag_rf_pkg::flag_rd_t                 ret,
  output logic [flag_rf_pkg::FLAG_W-1:0]        ret_flags,
  input  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr,
  input  flag_rf_pkg::flag_alloc_t              alloc,
  output logic                                  init_busy
);

  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr_q; // one cycle late
  flag_rf_pkg::flag_alloc_t alloc_q;
  flag_rf_pkg::flag_entry_t arr_data;

  flag_rf_array array_i (
    .clk(clk),
    .rst(rst),
    .rd(rd),
    .rd_data(arr_data),
    .ret(ret),
    .ret_flags(ret_flags),
    .wr(wr_q),
    .alloc(alloc_q),
    .init_busy(init_busy)
  );

  flag_rf_bypass bypass_i (
    .clk(clk),
    .rst(rst),
    .init_busy(init_busy),
    .wr(wr),
    .alloc(alloc),
    .wr_q(wr_q),
    .alloc_q(alloc_q),
    .rd(rd),
    .arr_data(arr_data),
    .rd_data(rd_data),
    .rd_bypass(rd_bypass)
  );

endmodule

// ==== flag_rf_array.sv ====
// all tiles plus the post-reset clear sweep; writes are ignored until the sweep is done
`timescale 1ns/1ps

module flag_rf_array (
  input  logic                                  clk,
  input  logic                                  rst,
  input  flag_rf_pkg::flag_rd_t                 rd,
  output flag_rf_pkg::flag_entry_t              rd_data,
  input  flag_rf_pkg::flag_rd_t                 ret,
  output logic [flag_rf_pkg::FLAG_W-1:0]        ret_flags,
  input  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr,
  input  flag_rf_pkg::flag_alloc_t              alloc,
  output logic                                  init_busy
);

  logic busy;
  logic [flag_rf_pkg::ROW_BITS-1:0] clr_row;

  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr_m;
  flag_rf_pkg::flag_alloc_t alloc_m;

  flag_rf_pkg::flag_entry_t tile_rd_data [flag_rf_pkg::TILE_COUNT];
  logic [flag_rf_pkg::FLAG_W-1:0] tile_ret_flags [flag_rf_pkg::TILE_COUNT];
  logic [flag_rf_pkg::TILE_COUNT-1:0] tile_rd_sel;
  logic [flag_rf_pkg::TILE_COUNT-1:0] tile_ret_sel;

  // one row of every tile and half per cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b1;
      clr_row <= '0;
    end
    else if (busy)
    begin
      clr_row <= clr_row + 1'b1;
      if (clr_row == flag_rf_pkg::ROW_BITS'(flag_rf_pkg::ROW_COUNT - 1))
        busy <= 1'b0;
    end
  end

  assign init_busy = busy;

  // the sweep owns the banks while busy
  always_comb
  begin
    wr_m = wr;
    for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
      wr_m[i].en = wr[i].en && !busy;
    alloc_m = alloc;
    alloc_m.en = alloc.en && !busy;
  end

  generate
    for (genvar t = 0; t < flag_rf_pkg::TILE_COUNT; t++)
    begin : g_tile
      flag_rf_tile #(
        .TILE(flag_rf_pkg::TILE_BITS'(t))
      ) tile_i (
        .clk(clk),
        .rst(rst),
        .rd(rd),
        .rd_data(tile_rd_data[t]),
        .ret(ret),
        .ret_flags(tile_ret_flags[t]),
        .ret_sel(tile_ret_sel[t]),
        .rd_sel(tile_rd_sel[t]),
        .clr_en(busy),
        .clr_row(clr_row),
        .wr(wr_m),
        .alloc(alloc_m)
      );
    end
  endgenerate

  // and-or select, zero when nothing selected
  always_comb
  begin
    rd_data = '0;
    ret_flags = '0;
    for (int t = 0; t < flag_rf_pkg::TILE_COUNT; t++)
    begin
      rd_data = rd_data | (tile_rd_data[t] & {flag_rf_pkg::ENTRY_W{tile_rd_sel[t]}});
      ret_flags = ret_flags | (tile_ret_flags[t] & {flag_rf_pkg::FLAG_W{tile_ret_sel[t]}});
    end
  end

endmodule

// ==== flag_rf_bank.sv ====
// one bank half; write-first async read behind registered rows, memory has no reset
`timescale 1ns/1ps

module flag_rf_bank (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rd_en,
  input  logic [flag_rf_pkg::ROW_BITS-1:0]      rd_row,
  output flag_rf_pkg::flag_entry_t              rd_data,
  input  logic                                  ret_en,
  input  logic [flag_rf_pkg::ROW_BITS-1:0]      ret_row,
  output logic [flag_rf_pkg::FLAG_W-1:0]        ret_flags,
  input  logic                                  clr_en,
  input  logic [flag_rf_pkg::ROW_BITS-1:0]      clr_row,
  input  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr,
  input  logic [flag_rf_pkg::WR_PORTS-1:0]      wr_hit,
  input  logic [flag_rf_pkg::ROW_BITS-1:0]      alloc_row,
  input  logic                                  alloc_hit
);

  flag_rf_pkg::flag_entry_t mem [flag_rf_pkg::ROW_COUNT];

  logic [flag_rf_pkg::ROW_BITS-1:0] rd_row_q;
  logic [flag_rf_pkg::ROW_BITS-1:0] ret_row_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_row_q <= '0;
      ret_row_q <= '0;
    end
    else
    begin
      if (rd_en)
        rd_row_q <= rd_row;
      if (ret_en)
        ret_row_q <= ret_row;
    end
  end

  // later statements win on the same row
  always_ff @(posedge clk)
  begin
    if (clr_en)
      mem[clr_row] <= '0;
    for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
    begin
      if (wr_hit[i])
      begin
        mem[wr[i].addr.row].invalid <= 1'b0;
        mem[wr[i].addr.row].flags <= wr[i].flags;
      end
    end
    if (alloc_hit)
      mem[alloc_row] <= '1; // marks entry invalid
  end

  // row regs sample at the edge, so data seen after it already holds that edge's writes
  assign rd_data = mem[rd_row_q];
  assign ret_flags = mem[ret_row_q].flags;

endmodule

// ==== flag_rf_bypass.sv ====
// write delay stage and read forwarding; requests seen while init_busy is high are dropped here
`timescale 1ns/1ps

module flag_rf_bypass (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  init_busy,
  input  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr,
  input  flag_rf_pkg::flag_alloc_t              alloc,
  output flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr_q,
  output flag_rf_pkg::flag_alloc_t              alloc_q,
  input  flag_rf_pkg::flag_rd_t                 rd,
  input  flag_rf_pkg::flag_entry_t              arr_data,
  output flag_rf_pkg::flag_entry_t              rd_data,
  output logic [flag_rf_pkg::WR_PORTS:0]        rd_bypass
);

  flag_rf_pkg::flag_rd_t rd_q;

  // payload follows every cycle, only the enables are reset
  always_ff @(posedge clk)
  begin
    wr_q <= wr;
    alloc_q <= alloc;
    rd_q <= rd;
    if (rst)
    begin
      for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
        wr_q[i].en <= 1'b0;
      alloc_q.en <= 1'b0;
      rd_q.en <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
        wr_q[i].en <= wr[i].en && !init_busy;
      alloc_q.en <= alloc.en && !init_busy;
    end
  end

  // registered requests are not in the ram yet
  // scan low to high so the last hit has priority: alloc > wr[1] > wr[0]
  always_comb
  begin
    rd_data = arr_data;
    rd_bypass = '0;
    for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
    begin
      if (rd_q.en && wr_q[i].en && (wr_q[i].addr == rd_q.addr))
      begin
        rd_data.invalid = 1'b0;
        rd_data.flags = wr_q[i].flags;
        rd_bypass = '0;
        rd_bypass[i] = 1'b1;
      end
    end
    if (rd_q.en && alloc_q.en && (alloc_q.addr == rd_q.addr))
    begin
      rd_data = '1; // fresh allocate reads as invalid
      rd_bypass = '0;
      rd_bypass[flag_rf_pkg::WR_PORTS] = 1'b1;
    end
  end

endmodule

// ==== flag_rf_checker.sv ====
// protocol checks bound into flag_rf; rst is synchronous and checks are off while it is high
`timescale 1ns/1ps

module flag_rf_checker (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rd_en,
  input  logic [flag_rf_pkg::WR_PORTS:0]        rd_bypass,
  input  logic                                  init_busy
);

  int fail_count = 0; // read by the testbench at the end

  // one source at most supplies a forwarded read
  a_bypass_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rd_bypass))
  else
  begin
    fail_count++;
    $error("rd_bypass has more than one bit set: %b", $sampled(rd_bypass));
  end

  // sweep runs once per reset
  a_busy_no_rise: assert property (@(posedge clk) disable iff (rst) !init_busy |=> !init_busy)
  else
  begin
    fail_count++;
    $error("init_busy rose again without a reset");
  end

  a_no_bypass_busy: assert property (@(posedge clk) disable iff (rst)
    (rd_en && init_busy) |=> (rd_bypass == '0))
  else
  begin
    fail_count++;
    $error("rd_bypass set after a read during init_busy: %b", $sampled(rd_bypass));
  end

endmodule

// ==== flag_rf_pkg.sv ====
// sizes and request types for the flags register file; 4 tiles x 2 halves x 8 rows, 2 result ports
package flag_rf_pkg;

  // entry contents
  localparam int FLAG_W = 6;
  localparam int ENTRY_W = FLAG_W + 1; // flags plus invalid bit

  // address split
  localparam int TILE_BITS = 2;
  localparam int TILE_COUNT = 1 << TILE_BITS;
  localparam int ROW_BITS = 3;
  localparam int ROW_COUNT = 1 << ROW_BITS;
  localparam int ADDR_W = 1 + ROW_BITS + TILE_BITS;

  localparam int WR_PORTS = 2; // result ports, alloc is extra

  // half picks the bank, tile is the low field
  typedef struct packed {
    logic half;
    logic [ROW_BITS-1:0] row;
    logic [TILE_BITS-1:0] tile;
  } flag_addr_t;

  typedef struct packed {
    logic invalid;
    logic [FLAG_W-1:0] flags;
  } flag_entry_t;

  // result write
  typedef struct packed {
    logic en;
    flag_addr_t addr;
    logic [FLAG_W-1:0] flags;
  } flag_wr_t;

  // allocate writes all ones, so no data
  typedef struct packed {
    logic en;
    flag_addr_t addr;
  } flag_alloc_t;

  // read port and retire port share this
  typedef struct packed {
    logic en;
    flag_addr_t addr;
  } flag_rd_t;

endpackage

// ==== flag_rf_tb.sv ====
// testbench for flag_rf; 64 entries, fixed-seed xorshift stimulus, model checked by assertions
`timescale 1ns/1ps

module flag_rf_tb;

  localparam int NUM_TESTS = 6;
  localparam int CLK_NS = 20;
  localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_NS;
  localparam int ENTRIES = 1 << flag_rf_pkg::ADDR_W;

  logic clk;
  logic rst;
  flag_rf_pkg::flag_rd_t rd;
  flag_rf_pkg::flag_rd_t ret;
  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr;
  flag_rf_pkg::flag_alloc_t alloc;
  flag_rf_pkg::flag_entry_t rd_data;
  logic [flag_rf_pkg::WR_PORTS:0] rd_bypass;
  logic [flag_rf_pkg::FLAG_W-1:0] ret_flags;
  logic init_busy;

  flag_rf_pkg::flag_entry_t model [ENTRIES];
  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] pend_wr; // sampled, not yet in ram
  flag_rf_pkg::flag_alloc_t pend_alloc;
  int busy_left;
  logic rd_chk;
  logic ret_chk;
  flag_rf_pkg::flag_entry_t exp_rd_data;
  logic [flag_rf_pkg::WR_PORTS:0] exp_bypass;
  logic [flag_rf_pkg::FLAG_W-1:0] exp_ret_flags;

  logic [31:0] rng;
  int err_count;
  int err_mark;
  int tests_passed;
  int tests_failed;
  flag_rf_pkg::flag_addr_t addrs [$];

  flag_rf flag_rf_i (
    .clk(clk),
    .rst(rst),
    .rd(rd),
    .rd_data(rd_data),
    .rd_bypass(rd_bypass),
    .ret(ret),
    .ret_flags(ret_flags),
    .wr(wr),
    .alloc(alloc),
    .init_busy(init_busy)
  );

  bind flag_rf flag_rf_checker checker_i (
    .clk(clk),
    .rst(rst),
    .rd_en(rd.en),
    .rd_bypass(rd_bypass),
    .init_busy(init_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // reference model, one step per rising edge
  always @(posedge clk)
  begin
    flag_rf_pkg::flag_entry_t ent;
    logic [flag_rf_pkg::WR_PORTS:0] byp;
    logic busy_now;
    logic hit;
    if (rst)
    begin
      for (int a = 0; a < ENTRIES; a++)
        model[a] = '0; // state after the sweep
      pend_wr = '0;
      pend_alloc = '0;
      busy_left = flag_rf_pkg::ROW_COUNT;
      rd_chk <= 1'b0;
      ret_chk <= 1'b0;
    end
    else
    begin
      busy_now = (busy_left != 0);
      for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
        if (pend_wr[i].en)
          model[pend_wr[i].addr] = {1'b0, pend_wr[i].flags};
      if (pend_alloc.en)
        model[pend_alloc.addr] = '1;
      exp_ret_flags <= model[ret.addr].flags; // retire sees no forwarding
      ret_chk <= ret.en && !busy_now;
      ent = model[rd.addr];
      byp = '0;
      hit = 1'b0;
      if (alloc.en && !busy_now && alloc.addr == rd.addr)
      begin
        ent = '1;
        byp[flag_rf_pkg::WR_PORTS] = 1'b1;
        hit = 1'b1;
      end
      for (int i = flag_rf_pkg::WR_PORTS - 1; i >= 0; i--)
        if (!hit && wr[i].en && !busy_now && wr[i].addr == rd.addr)
        begin
          ent = {1'b0, wr[i].flags};
          byp[i] = 1'b1;
          hit = 1'b1;
        end
      exp_rd_data <= ent;
      exp_bypass <= byp;
      rd_chk <= rd.en && !busy_now;
      pend_wr = wr;
      pend_alloc = alloc;
      for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
        pend_wr[i].en = wr[i].en && !busy_now; // dropped during the sweep
      pend_alloc.en = alloc.en && !busy_now;
      if (busy_left != 0)
        busy_left--;
    end
  end

  a_rd_data: assert property (@(posedge clk) disable iff (rst) rd_chk |-> rd_data == exp_rd_data)
  else
  begin
    err_count++;
    $display("Mismatch at %0t: rd_data expected %h, got %h", $time,
      $sampled(exp_rd_data), $sampled(rd_data));
  end

  a_rd_bypass: assert property (@(posedge clk) disable iff (rst)
    rd_chk |-> rd_bypass == exp_bypass)
  else
  begin
    err_count++;
    $display("Mismatch at %0t: rd_bypass expected %b, got %b", $time,
      $sampled(exp_bypass), $sampled(rd_bypass));
  end

  a_ret_flags: assert property (@(posedge clk) disable iff (rst)
    ret_chk |-> ret_flags == exp_ret_flags)
  else
  begin
    err_count++;
    $display("Mismatch at %0t: ret_flags expected %h, got %h", $time,
      $sampled(exp_ret_flags), $sampled(ret_flags));
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift(rng);
    r = rng;
  endtask

  task automatic clear_inputs();
    rd = '0;
    ret = '0;
    wr = '0;
    alloc = '0;
  endtask

  // inputs change only on the falling edge
  task automatic next_cycle();
    @(negedge clk);
    clear_inputs();
  endtask

  function automatic int total_errors();
    return err_count + flag_rf_i.checker_i.fail_count;
  endfunction

  task automatic report_test(input int num, input string name);
    int n;
    next_cycle();
    next_cycle(); // last check lands in here
    n = total_errors() - err_mark;
    err_mark = total_errors();
    if (n == 0)
      tests_passed++;
    else
      tests_failed++;
    $display("test %0d %s: %s, %0d errors", num, name, (n == 0) ? "ok" : "FAILED", n);
  endtask

  task automatic read_back(input logic use_ret);
    foreach (addrs[k])
    begin
      rd.en = !use_ret;
      rd.addr = addrs[k];
      ret.en = use_ret;
      ret.addr = addrs[k];
      next_cycle();
    end
  endtask

  task automatic sweep_after_reset();
    int busy_cycles;
    logic [31:0] r;
    busy_cycles = 0;
    while (init_busy && busy_cycles < 4 * flag_rf_pkg::ROW_COUNT)
    begin
      busy_cycles++;
      next_rand(r);
      wr[0].en = 1'b1;
      wr[0].addr = r[5:0];
      wr[0].flags = r[11:6];
      wr[1].en = 1'b1;
      wr[1].addr = r[17:12];
      wr[1].flags = r[23:18];
      alloc.en = r[24];
      alloc.addr = r[30:25];
      rd.en = busy_cycles > flag_rf_pkg::ROW_COUNT / 2;
      rd.addr = r[5:0];
      next_cycle();
    end
    assert (busy_cycles == flag_rf_pkg::ROW_COUNT)
    else
    begin
      err_count++;
      $display("init_busy was high for %0d cycles, expected %0d", busy_cycles,
        flag_rf_pkg::ROW_COUNT);
    end
    addrs.delete();
    for (int a = 0; a < ENTRIES; a++)
      addrs.push_back(a[5:0]);
    foreach (addrs[k])
    begin
      rd.en = 1'b1;
      rd.addr = addrs[k];
      ret.en = 1'b1;
      ret.addr = addrs[k];
      next_cycle();
    end
    report_test(1, "init sweep");
  endtask

  task automatic write_then_read();
    logic [31:0] r;
    addrs.delete();
    repeat (16)
    begin
      for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
      begin
        next_rand(r);
        wr[i].en = 1'b1;
        wr[i].addr = r[5:0];
        wr[i].flags = r[13:8];
        addrs.push_back(r[5:0]);
      end
      next_cycle();
    end
    next_cycle();
    read_back(1'b0);
    report_test(2, "random writes");
  endtask

  task automatic alloc_then_read();
    logic [31:0] r;
    addrs.delete();
    repeat (8)
    begin
      next_rand(r);
      alloc.en = 1'b1;
      alloc.addr = r[5:0];
      addrs.push_back(r[5:0]);
      next_cycle();
    end
    next_cycle();
    read_back(1'b0);
    report_test(3, "allocate");
  endtask

  task automatic forward_same_edge();
    logic [31:0] r;
    int src;
    repeat (24)
    begin
      next_rand(r);
      src = r[9:8] % 3; // 2 picks alloc
      if (src == flag_rf_pkg::WR_PORTS)
      begin
        alloc.en = 1'b1;
        alloc.addr = r[5:0];
      end
      else
      begin
        wr[src].en = 1'b1;
        wr[src].addr = r[5:0];
        wr[src].flags = r[15:10];
      end
      rd.en = 1'b1;
      rd.addr = r[16] ? r[21:16] : r[5:0]; // sometimes another entry
      next_cycle();
    end
    report_test(4, "forwarding");
  endtask

  task automatic resolve_conflicts();
    logic [31:0] r;
    logic [flag_rf_pkg::WR_PORTS:0] sel;
    addrs.delete();
    repeat (16)
    begin
      next_rand(r);
      sel = r[8:6];
      if (sel == '0)
        sel = '1;
      for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
        if (sel[i])
        begin
          wr[i].en = 1'b1;
          wr[i].addr = r[5:0];
          wr[i].flags = r[14 + 6 * i +: 6];
        end
      alloc.en = sel[flag_rf_pkg::WR_PORTS];
      alloc.addr = r[5:0];
      rd.en = 1'b1;
      rd.addr = r[5:0];
      addrs.push_back(r[5:0]);
      next_cycle();
    end
    next_cycle();
    read_back(1'b0);
    report_test(5, "same-address priority");
  endtask

  task automatic retire_after_write();
    logic [31:0] r;
    flag_rf_pkg::flag_addr_t last;
    addrs.delete();
    last = '0;
    repeat (16)
    begin
      next_rand(r);
      wr[0].en = 1'b1;
      wr[0].addr = r[5:0];
      wr[0].flags = r[11:6];
      ret.en = 1'b1;
      ret.addr = r[12] ? last : r[5:0]; // same edge must still see the old value
      last = r[5:0];
      addrs.push_back(r[5:0]);
      next_cycle();
    end
    next_cycle();
    read_back(1'b1);
    report_test(6, "retire read");
  endtask

  initial
  begin
    rng = 32'd55210;
    err_count = 0;
    err_mark = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst = 1'b1;
    clear_inputs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    sweep_after_reset();
    write_then_read();
    alloc_then_read();
    forward_same_edge();
    resolve_conflicts();
    retire_after_write();
    $display("tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
      total_errors());
    if (tests_failed == 0 && total_errors() == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== flag_rf_tile.sv ====
// one tile of two bank halves; TILE must be below TILE_COUNT, select holds until the next read
`timescale 1ns/1ps

module flag_rf_tile #(
  parameter logic [flag_rf_pkg::TILE_BITS-1:0] TILE = '0
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  flag_rf_pkg::flag_rd_t                 rd,
  output flag_rf_pkg::flag_entry_t              rd_data,
  input  flag_rf_pkg::flag_rd_t                 ret,
  output logic [flag_rf_pkg::FLAG_W-1:0]        ret_flags,
  output logic                                  ret_sel,
  output logic                                  rd_sel,
  input  logic                                  clr_en,
  input  logic [flag_rf_pkg::ROW_BITS-1:0]      clr_row,
  input  flag_rf_pkg::flag_wr_t [flag_rf_pkg::WR_PORTS-1:0] wr,
  input  flag_rf_pkg::flag_alloc_t              alloc
);

  logic rd_tile;
  logic ret_tile;
  logic alloc_tile;
  logic [flag_rf_pkg::WR_PORTS-1:0] wr_lo;
  logic [flag_rf_pkg::WR_PORTS-1:0] wr_hi;
  logic rd_lo_q, rd_hi_q;
  logic ret_lo_q, ret_hi_q;
  flag_rf_pkg::flag_entry_t rd_data_lo, rd_data_hi;
  logic [flag_rf_pkg::FLAG_W-1:0] ret_flags_lo, ret_flags_hi;

  assign rd_tile = rd.en && (rd.addr.tile == TILE);
  assign ret_tile = ret.en && (ret.addr.tile == TILE);
  assign alloc_tile = alloc.en && (alloc.addr.tile == TILE);

  always_comb
  begin
    for (int i = 0; i < flag_rf_pkg::WR_PORTS; i++)
    begin
      wr_lo[i] = wr[i].en && (wr[i].addr.tile == TILE) && !wr[i].addr.half;
      wr_hi[i] = wr[i].en && (wr[i].addr.tile == TILE) && wr[i].addr.half;
    end
  end

  // any read updates the select, so a read elsewhere deselects this tile
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_lo_q <= 1'b0;
      rd_hi_q <= 1'b0;
      ret_lo_q <= 1'b0;
      ret_hi_q <= 1'b0;
    end
    else
    begin
      if (rd.en)
      begin
        rd_lo_q <= rd_tile && !rd.addr.half;
        rd_hi_q <= rd_tile && rd.addr.half;
      end
      if (ret.en)
      begin
        ret_lo_q <= ret_tile && !ret.addr.half;
        ret_hi_q <= ret_tile && ret.addr.half;
      end
    end
  end

  flag_rf_bank bank_lo_i (
    .clk(clk), .rst(rst),
    .rd_en(rd_tile && !rd.addr.half), .rd_row(rd.addr.row), .rd_data(rd_data_lo),
    .ret_en(ret_tile && !ret.addr.half), .ret_row(ret.addr.row), .ret_flags(ret_flags_lo),
    .clr_en(clr_en), .clr_row(clr_row),
    .wr(wr), .wr_hit(wr_lo),
    .alloc_row(alloc.addr.row), .alloc_hit(alloc_tile && !alloc.addr.half)
  );

  flag_rf_bank bank_hi_i (
    .clk(clk), .rst(rst),
    .rd_en(rd_tile && rd.addr.half), .rd_row(rd.addr.row), .rd_data(rd_data_hi),
    .ret_en(ret_tile && ret.addr.half), .ret_row(ret.addr.row), .ret_flags(ret_flags_hi),
    .clr_en(clr_en), .clr_row(clr_row),
    .wr(wr), .wr_hit(wr_hi),
    .alloc_row(alloc.addr.row), .alloc_hit(alloc_tile && alloc.addr.half)
  );

  assign rd_sel = rd_lo_q | rd_hi_q;
  assign ret_sel = ret_lo_q | ret_hi_q;
  assign rd_data = rd_hi_q ? rd_data_hi : rd_data_lo; // array gates with rd_sel
  assign ret_flags = ret_hi_q ? ret_flags_hi : ret_flags_lo;

endmodule
